/* rename_config.svh */
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// register counts
`define NUM_ARCH_REGS 16
`define NUM_PHYS_REGS 64

// entries per pair queue, in and out
`define QUEUE_DEPTH 4

// datapath widths
`define DATA_W 64
`define IMM_W 16
`define PC_W 32

`endif

/* uop_pkg.sv */
`include "rename_config.svh"

package uop_pkg;

  // architectural register index
  typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] arch_reg_t;

  // one decoded instruction as it leaves the decoder
  typedef struct packed {
    logic [`PC_W-1:0]  pc;
    logic [7:0]        opcode;
    logic              valb_sel;  // 1 = src2 is a register, 0 = imm
    arch_reg_t         dst;
    arch_reg_t         src1;
    arch_reg_t         src2;      // ignored when valb_sel is 0
    logic [`IMM_W-1:0] imm;
  } uop_insn;

  // slot 0 is the older instruction
  typedef uop_insn [1:0] uop_pair_t;

endpackage

/* rob_pkg.sv */
`include "rename_config.svh"

package rob_pkg;
  import uop_pkg::*;

  // physical register index
  typedef logic [$clog2(`NUM_PHYS_REGS)-1:0] phys_reg_t;

  typedef enum logic [1:0] {
    ISSUED    = 2'd0,
    DONE      = 2'd1,
    COMMITTED = 2'd2
  } rob_status_t;

  // one renamed instruction headed for the rob
  typedef struct packed {
    logic [`PC_W-1:0] pc;
    logic [`PC_W-1:0] next_pc;
    uop_insn          uop;
    phys_reg_t        r1_reg_phys;
    phys_reg_t        r2_reg_phys;    // imm register when valb_sel is 0
    phys_reg_t        dest_reg_phys;
    rob_status_t      status;
  } rob_entry;

  typedef rob_entry [1:0] rob_pair_t;

  // register file write port, driven by rename for immediates
  typedef struct packed {
    logic              en;
    phys_reg_t         index_in;
    logic [`DATA_W-1:0] data_in;
  } regfile_write_port;

endpackage

/* uop_queue.sv */
`include "rename_config.svh"

// show-ahead FIFO whose head is valid in the cycle after the push edge
module uop_queue #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst_N_in,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output logic head_valid,
  output T     head_data,
  output logic full,
  output logic two_free
);

  localparam int DEPTH = `QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  T mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none, or push and pop together
      endcase
    end
  end

  // entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  assign head_valid = (count != '0);
  assign head_data  = mem[rd_ptr];
  assign full       = (count == CNT_W'(DEPTH));
  assign two_free   = (count <= CNT_W'(DEPTH - 2));  // room for one in flight plus one more

  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_N_in)
    push |-> !full);
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_N_in)
    pop |-> head_valid);

endmodule

/* free_list.sv */
`include "rename_config.svh"

module free_list
  import rob_pkg::*;
(
  input  logic                clk,
  input  logic                rst_N_in,
  output phys_reg_t [3:0]     free_register_data,  // lowest free first
  output logic                frl_valid,
  input  logic [3:0]          frl_ready,           // take mask
  input  logic                reclaim_valid,
  input  phys_reg_t           reclaim_reg
);

  localparam int NP = `NUM_PHYS_REGS;
  localparam int NA = `NUM_ARCH_REGS;

  // the identity-mapped registers start out busy
  localparam logic [NP-1:0] FREE_AT_RESET = {{(NP - NA){1'b1}}, {NA{1'b0}}};

  logic [NP-1:0] free_q;
  logic [NP-1:0] free_d;
  logic [2:0]    n_found;

  // priority scan for the four lowest set bits
  always_comb begin
    n_found = '0;
    free_register_data = '0;
    for (int r = 0; r < NP; r++) begin
      if (free_q[r] && n_found < 3'd4) begin
        free_register_data[n_found[1:0]] = phys_reg_t'(r);
        n_found = n_found + 3'd1;
      end
    end
  end

  assign frl_valid = (n_found == 3'd4);

  always_comb begin
    free_d = free_q;
    for (int i = 0; i < 4; i++) begin
      if (frl_ready[i]) begin
        free_d[free_register_data[i]] = 1'b0;
      end
    end
    // reclaim after take, so take and reclaim of one reg leaves it free
    if (reclaim_valid) begin
      free_d[reclaim_reg] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      free_q <= FREE_AT_RESET;
    end else begin
      free_q <= free_d;
    end
  end

  // rename may only consume what was offered as a full set of four
  a_take_needs_valid: assert property (@(posedge clk) disable iff (!rst_N_in)
    (|frl_ready) |-> frl_valid);

  // commit must not hand back a register nobody holds
  a_no_double_free: assert property (@(posedge clk) disable iff (!rst_N_in)
    reclaim_valid |-> !free_q[reclaim_reg]);

endmodule

/* rat.sv */
`include "rename_config.svh"

module rat
  import uop_pkg::*;
  import rob_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_N_in,

  // from the input queue head
  input  logic                      q_valid,
  input  uop_pair_t                 instr,
  output logic                      q_increment_ready,  // pop in the cycle of progress

  // to the output buffer
  output rob_pair_t                 rob_data,
  output logic                      rob_data_valid,
  input  logic                      rob_ready,

  // free list handshake
  output logic [3:0]                frl_ready,
  input  phys_reg_t [3:0]           free_register_data,
  input  logic                      frl_valid,

  // immediate writes into the register file
  output regfile_write_port [1:0]   regfile
);

  logic      progress;
  phys_reg_t map_q [`NUM_ARCH_REGS];  // arch -> phys
  rob_pair_t rob_d;

  // all three sides must agree in one cycle
  assign progress = q_valid && frl_valid && rob_ready;

  assign q_increment_ready = progress;

  // 0,1 = destinations, 2+i = imm register of slot i
  assign frl_ready[0] = progress;
  assign frl_ready[1] = progress;
  assign frl_ready[2] = progress && !instr[0].valb_sel;
  assign frl_ready[3] = progress && !instr[1].valb_sel;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      rob_d[i].pc            = instr[i].pc;
      rob_d[i].next_pc       = instr[i].pc;  // no next pc logic yet
      rob_d[i].uop           = instr[i];
      rob_d[i].r1_reg_phys   = map_q[instr[i].src1];
      if (instr[i].valb_sel) begin
        rob_d[i].r2_reg_phys = map_q[instr[i].src2];
      end else begin
        rob_d[i].r2_reg_phys = free_register_data[2+i];  // holds the imm
      end
      rob_d[i].dest_reg_phys = free_register_data[i];
      rob_d[i].status        = ISSUED;
    end

    // slot 1 sees slot 0's new mapping, not the table
    if (instr[1].src1 == instr[0].dst) begin
      rob_d[1].r1_reg_phys = free_register_data[0];
    end
    if (instr[1].valb_sel && instr[1].src2 == instr[0].dst) begin
      rob_d[1].r2_reg_phys = free_register_data[0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      rob_data_valid <= 1'b0;
      for (int i = 0; i < 2; i++) begin
        regfile[i].en <= 1'b0;
      end
      for (int a = 0; a < `NUM_ARCH_REGS; a++) begin
        map_q[a] <= phys_reg_t'(a);  // identity map
      end
    end else begin
      rob_data_valid <= progress;
      for (int i = 0; i < 2; i++) begin
        regfile[i].en       <= progress && !instr[i].valb_sel;
        regfile[i].index_in <= free_register_data[2+i];
        regfile[i].data_in  <= {{(`DATA_W - `IMM_W){1'b0}}, instr[i].imm};
      end
      if (progress) begin
        rob_data <= rob_d;
        map_q[instr[0].dst] <= free_register_data[0];
        // with the same dst in both slots this later write wins
        map_q[instr[1].dst] <= free_register_data[1];
      end
    end
  end

  // the two slots of one pair never get the same new register
  a_distinct_dests: assert property (@(posedge clk) disable iff (!rst_N_in)
    rob_data_valid |-> (rob_data[0].dest_reg_phys != rob_data[1].dest_reg_phys));

endmodule

/* phys_regfile.sv */
`include "rename_config.svh"

module phys_regfile
  import rob_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_N_in,
  input  regfile_write_port [1:0]   wr,
  input  phys_reg_t                 raddr,
  output logic [`DATA_W-1:0]        rdata
);

  logic [`DATA_W-1:0] regs [`NUM_PHYS_REGS];

  always_ff @(posedge clk) begin
    if (!rst_N_in) begin
      for (int r = 0; r < `NUM_PHYS_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      // port 1 last so slot 1 wins on a clash
      for (int p = 0; p < 2; p++) begin
        if (wr[p].en) begin
          regs[wr[p].index_in] <= wr[p].data_in;
        end
      end
    end
  end

  assign rdata = regs[raddr];  // combinational read

  // free list offers distinct registers, so two writes never collide
  a_distinct_ports: assert property (@(posedge clk) disable iff (!rst_N_in)
    (wr[0].en && wr[1].en) |-> (wr[0].index_in != wr[1].index_in));

endmodule

/* rename_top.sv */
`include "rename_config.svh"

module rename_top
  import uop_pkg::*;
  import rob_pkg::*;
(
  input  logic               clk,
  input  logic               rst_N_in,

  input  logic               in_valid,
  input  uop_pair_t          in_instr,
  output logic               in_ready,

  output logic               out_valid,
  output rob_pair_t          out_data,
  input  logic               out_pop,

  input  logic               reclaim_valid,
  input  phys_reg_t          reclaim_reg,

  input  phys_reg_t          rf_raddr,
  output logic [`DATA_W-1:0] rf_rdata
);

  logic                    in_full;
  logic                    q_valid;
  uop_pair_t               q_instr;
  logic                    q_pop;
  rob_pair_t               rob_data;
  logic                    rob_data_valid;
  logic                    rob_ready;
  phys_reg_t [3:0]         free_regs;
  logic                    frl_valid;
  logic [3:0]              frl_ready;
  regfile_write_port [1:0] rf_wr;

  assign in_ready = !in_full;

  uop_queue #(.T(uop_pair_t)) u_in_q (
    .clk        (clk),
    .rst_N_in   (rst_N_in),
    .push       (in_valid && in_ready),
    .push_data  (in_instr),
    .pop        (q_pop),
    .head_valid (q_valid),
    .head_data  (q_instr),
    .full       (in_full),
    .two_free   ()
  );

  free_list u_frl (
    .clk                (clk),
    .rst_N_in           (rst_N_in),
    .free_register_data (free_regs),
    .frl_valid          (frl_valid),
    .frl_ready          (frl_ready),
    .reclaim_valid      (reclaim_valid),
    .reclaim_reg        (reclaim_reg)
  );

  rat u_rat (
    .clk                (clk),
    .rst_N_in           (rst_N_in),
    .q_valid            (q_valid),
    .instr              (q_instr),
    .q_increment_ready  (q_pop),
    .rob_data           (rob_data),
    .rob_data_valid     (rob_data_valid),
    .rob_ready          (rob_ready),
    .frl_ready          (frl_ready),
    .free_register_data (free_regs),
    .frl_valid          (frl_valid),
    .regfile            (rf_wr)
  );

  // stands in for the rob
  uop_queue #(.T(rob_pair_t)) u_out_q (
    .clk        (clk),
    .rst_N_in   (rst_N_in),
    .push       (rob_data_valid),
    .push_data  (rob_data),
    .pop        (out_pop && out_valid),
    .head_valid (out_valid),
    .head_data  (out_data),
    .full       (),
    .two_free   (rob_ready)
  );

  phys_regfile u_prf (
    .clk      (clk),
    .rst_N_in (rst_N_in),
    .wr       (rf_wr),
    .raddr    (rf_raddr),
    .rdata    (rf_rdata)
  );

endmodule

/* tb_clock.sv */
// free-running testbench clock
module tb_clock #(
  parameter int PERIOD = 10
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

endmodule

/* rename_tb.sv */
module rename_tb
  import uop_pkg::*;
  import rob_pkg::*;
();

  localparam int NUM_ROWS  = 15;
  localparam int LAST_FILL = 13;  // rows 6..13 drain the free list
  localparam int WATCHDOG  = (NUM_ROWS * 3 + 50) * 10;

  logic        clk;
  logic        rst_N_in;
  logic        in_valid;
  uop_pair_t   in_instr;
  logic        in_ready;
  logic        out_valid;
  rob_pair_t   out_data;
  logic        out_pop;
  logic        reclaim_valid;
  phys_reg_t   reclaim_reg;
  phys_reg_t   rf_raddr;
  logic [63:0] rf_rdata;

  uop_pair_t   rows [NUM_ROWS];
  phys_reg_t   exp_r1 [NUM_ROWS][2];
  phys_reg_t   exp_r2 [NUM_ROWS][2];
  phys_reg_t   exp_dst [NUM_ROWS][2];
  int          drive_edge [NUM_ROWS];  // edge index where each row was driven
  int          cyc;
  int          lat;
  bit          seen_first;
  logic [15:0] lfsr;
  int          err_count;
  int          pass_count;
  int          fail_count;

  tb_clock u_clk (.clk(clk));

  rename_top DUT (
    .clk           (clk),
    .rst_N_in      (rst_N_in),
    .in_valid      (in_valid),
    .in_instr      (in_instr),
    .in_ready      (in_ready),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .out_pop       (out_pop),
    .reclaim_valid (reclaim_valid),
    .reclaim_reg   (reclaim_reg),
    .rf_raddr      (rf_raddr),
    .rf_rdata      (rf_rdata)
  );

  always_ff @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // 16-bit fibonacci with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic add_slot(input int k, input int s, input logic valb, input arch_reg_t dst,
                          input arch_reg_t src1, input arch_reg_t src2, input logic [15:0] imm,
                          input phys_reg_t r1, input phys_reg_t r2, input phys_reg_t d);
    rows[k][s].pc       = 32'(32'h1000 + k * 8 + s * 4);
    rows[k][s].opcode   = 8'(8'h20 + k);
    rows[k][s].valb_sel = valb;
    rows[k][s].dst      = dst;
    rows[k][s].src1     = src1;
    rows[k][s].src2     = src2;
    rows[k][s].imm      = imm;
    exp_r1[k][s]        = r1;
    exp_r2[k][s]        = r2;
    exp_dst[k][s]       = d;
  endtask

  // columns: row slot valb dst src1 src2 imm | r1 r2 dest
  task automatic build_table;
    int base;
    add_slot(0, 0, 1'b1, 4'd1, 4'd2, 4'd3, 16'h0000, 6'd2, 6'd3, 6'd16);
    add_slot(0, 1, 1'b1, 4'd4, 4'd5, 4'd6, 16'h0000, 6'd5, 6'd6, 6'd17);
    add_slot(1, 0, 1'b0, 4'd2, 4'd1, 4'd0, 16'h1234, 6'd16, 6'd20, 6'd18);
    add_slot(1, 1, 1'b0, 4'd3, 4'd4, 4'd0, 16'hbeef, 6'd17, 6'd21, 6'd19);
    add_slot(2, 0, 1'b1, 4'd5, 4'd2, 4'd3, 16'h0000, 6'd18, 6'd19, 6'd22);
    add_slot(2, 1, 1'b1, 4'd6, 4'd5, 4'd5, 16'h0000, 6'd22, 6'd22, 6'd23);  // bypass
    add_slot(3, 0, 1'b1, 4'd7, 4'd0, 4'd0, 16'h0000, 6'd0, 6'd0, 6'd24);
    add_slot(3, 1, 1'b1, 4'd7, 4'd7, 4'd1, 16'h0000, 6'd24, 6'd16, 6'd25);  // same dst
    add_slot(4, 0, 1'b1, 4'd8, 4'd7, 4'd6, 16'h0000, 6'd25, 6'd23, 6'd26);
    add_slot(4, 1, 1'b0, 4'd9, 4'd3, 4'd0, 16'h00ff, 6'd19, 6'd29, 6'd27);  // 28 skipped
    add_slot(5, 0, 1'b0, 4'd10, 4'd9, 4'd0, 16'h8001, 6'd27, 6'd31, 6'd28);
    add_slot(5, 1, 1'b1, 4'd11, 4'd10, 4'd8, 16'h0000, 6'd28, 6'd26, 6'd30);
    for (int k = 6; k <= LAST_FILL; k++) begin
      base = 32 + 4 * (k - 6);  // four in a row from 32 up
      add_slot(k, 0, 1'b0, 4'd12, 4'd0, 4'd0, 16'(k * 256 + 160),
               6'd0, phys_reg_t'(base + 2), phys_reg_t'(base));
      add_slot(k, 1, 1'b0, 4'd13, 4'd0, 4'd0, 16'(k * 256 + 176),
               6'd0, phys_reg_t'(base + 3), phys_reg_t'(base + 1));
    end
    // only reclaimed 2 5 7 24 are free here
    add_slot(14, 0, 1'b0, 4'd14, 4'd1, 4'd0, 16'h0a0a, 6'd16, 6'd7, 6'd2);
    add_slot(14, 1, 1'b0, 4'd15, 4'd14, 4'd0, 16'h5050, 6'd2, 6'd24, 6'd5);
  endtask

  task automatic check_val(input string sig, input logic [127:0] got, input logic [127:0] want);
    assert (got === want) else begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", sig, got, want);
      err_count++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      pass_count++;
      $display("test %s: passed", name);
    end else begin
      fail_count++;
      $display("test %s: FAILED", name);
    end
  endtask

  task automatic check_row(input int k);
    int    errs_before;
    string tag;
    errs_before = err_count;
    for (int s = 0; s < 2; s++) begin
      tag = $sformatf("out_data[%0d]", s);
      check_val({tag, ".pc"}, 128'(out_data[s].pc), 128'(rows[k][s].pc));
      check_val({tag, ".next_pc"}, 128'(out_data[s].next_pc), 128'(rows[k][s].pc));
      check_val({tag, ".uop"}, 128'(out_data[s].uop), 128'(rows[k][s]));
      check_val({tag, ".r1_reg_phys"}, 128'(out_data[s].r1_reg_phys), 128'(exp_r1[k][s]));
      check_val({tag, ".r2_reg_phys"}, 128'(out_data[s].r2_reg_phys), 128'(exp_r2[k][s]));
      check_val({tag, ".dest_reg_phys"}, 128'(out_data[s].dest_reg_phys), 128'(exp_dst[k][s]));
      check_val({tag, ".status"}, 128'(out_data[s].status), 128'(ISSUED));
    end
    finish_test($sformatf("row %0d", k), errs_before);
  endtask

  task automatic drive_rows;
    for (int k = 0; k < NUM_ROWS; k++) begin
      @(posedge clk);
      in_valid      <= 1'b1;
      in_instr      <= rows[k];
      drive_edge[k] = cyc;
      @(negedge clk);
      while (!in_ready) begin
        @(negedge clk);
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // pops with random stalls and checks each entry as it leaves
  task automatic consume_rows(input int first, input int last);
    int   k;
    logic b;
    k = first;
    while (k <= last) begin
      @(posedge clk);
      lfsr = lfsr_step(lfsr);
      b = lfsr[0];
      lfsr = lfsr_step(lfsr);
      out_pop <= b | lfsr[0];  // stalls about one cycle in four
      @(negedge clk);
      if (out_valid && !seen_first) begin
        seen_first = 1'b1;
        lat = cyc - 1 - drive_edge[0];
      end
      if (out_valid && out_pop) begin
        check_row(k);
        k++;
      end
    end
    @(posedge clk);
    out_pop <= 1'b0;
  endtask

  task automatic reclaim_regs;
    phys_reg_t order [4];
    order = '{6'd24, 6'd7, 6'd5, 6'd2};
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      reclaim_valid <= 1'b1;
      reclaim_reg   <= order[i];
    end
    @(posedge clk);
    reclaim_valid <= 1'b0;
  endtask

  task automatic check_regfile;
    int errs_before;
    errs_before = err_count;
    for (int k = 0; k < NUM_ROWS; k++) begin
      for (int s = 0; s < 2; s++) begin
        if (!rows[k][s].valb_sel) begin
          @(posedge clk);
          rf_raddr <= exp_r2[k][s];
          @(negedge clk);
          check_val($sformatf("rf_rdata at p%0d", exp_r2[k][s]), 128'(rf_rdata),
                    128'(rows[k][s].imm));
        end
      end
    end
    finish_test("regfile immediates", errs_before);
  endtask

  initial begin
    int errs_before;
    rst_N_in      <= 1'b0;
    in_valid      <= 1'b0;
    in_instr      <= '0;
    out_pop       <= 1'b0;
    reclaim_valid <= 1'b0;
    reclaim_reg   <= '0;
    rf_raddr      <= '0;
    lfsr       = 16'd57786;
    err_count  = 0;
    pass_count = 0;
    fail_count = 0;
    seen_first = 1'b0;
    lat        = 0;
    build_table();
    repeat (3) @(posedge clk);
    rst_N_in <= 1'b1;

    @(negedge clk);
    errs_before = err_count;
    check_val("in_ready", 128'(in_ready), 128'(1'b1));
    check_val("out_valid", 128'(out_valid), 128'(1'b0));
    finish_test("reset state", errs_before);

    fork
      drive_rows();
      consume_rows(0, LAST_FILL);
    join

    errs_before = err_count;
    check_val("first row latency in cycles", 128'(lat), 128'(3));
    finish_test("push to output latency", errs_before);

    // row 14 is queued but no four registers are free
    errs_before = err_count;
    repeat (10) begin
      @(negedge clk);
      assert (!out_valid) else begin
        $display("output appeared while the free list was empty");
        err_count++;
      end
    end
    finish_test("stall on empty free list", errs_before);

    reclaim_regs();
    consume_rows(14, 14);
    check_regfile();

    $display("%0d tests passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG);
    $display("watchdog expired before all tests finished");
    $display("Something failed");
    $finish;
  end

endmodule

/* src.f */
+incdir+.
uop_pkg.sv
rob_pkg.sv
uop_queue.sv
free_list.sv
rat.sv
phys_regfile.sv
rename_top.sv
tb_clock.sv
rename_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module rename_tb -f src.f -o rename_sim

# the simulator status alone is not trusted, the log decides
./obj_dir/rename_sim | tee sim.log

if grep -q "^Everything OK$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
